// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_modulation_timer
FILELIST  = src.f

OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx 'sim passed' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== source/mod_timer_pkg.sv ====
`default_nettype none

package mod_timer_pkg;

  ////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////
  parameter int TIME_W     = 57;
  parameter int TIME_SHIFT = 9;                   // Low time bits dropped
  parameter int DVD_W      = TIME_W - TIME_SHIFT; // 48
  parameter int DVS_W      = 16;
  parameter int CYCLE_W    = 15;

  parameter int NUM_SEGMENT_DEF = 2;

  // One input stage plus one stage per quotient bit
  function automatic int div_latency(input int dvd_w);
    return dvd_w + 1;
  endfunction

  // Two chained dividers, the index register and one spare cycle
  parameter int SETTLE_LAT = 2 * div_latency(DVD_W) + 2;

endpackage

`default_nettype wire

// ==== source/modulation_index.sv ====
`default_nettype none

module modulation_index
  import mod_timer_pkg::*;
(
  input  logic               CLK,
  input  logic               rst_n,
  input  logic [TIME_W-1:0]  sys_time,
  input  logic [DVS_W-1:0]   freq_div,
  input  logic [DVS_W-1:0]   cycle_len,
  output logic [CYCLE_W-1:0] idx
);

  logic [DVD_W-1:0] cnt_quo;
  logic             cnt_vld;
  logic [DVS_W-1:0] idx_rem;
  logic             idx_vld;

  ////////////////////////////////////////
  // Time / freq_div
  ////////////////////////////////////////
  pipe_divider #(
    .DVD_W(DVD_W),
    .DVS_W(DVS_W)
  ) div_cnt (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .dividend  (sys_time[TIME_W-1:TIME_SHIFT]),
    .divisor   (freq_div),
    .in_valid  (1'b1),          // Always a new sample
    .quotient  (cnt_quo),
    .remainder (),
    .dout_valid(cnt_vld)
  );

  ////////////////////////////////////////
  // Count mod cycle_len
  ////////////////////////////////////////
  pipe_divider #(
    .DVD_W(DVD_W),
    .DVS_W(DVS_W)
  ) div_idx (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .dividend  (cnt_quo),
    .divisor   (cycle_len),     // Static between updates
    .in_valid  (cnt_vld),
    .quotient  (),
    .remainder (idx_rem),
    .dout_valid(idx_vld)
  );

  // Remainder is below cycle_len, so 15 bits always hold it
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      idx <= '0;
    end else if (idx_vld) begin
      idx <= idx_rem[CYCLE_W-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== source/modulation_timer.sv ====
`default_nettype none

module modulation_timer
  import mod_timer_pkg::*;
#(
  parameter int NUM_SEGMENT = NUM_SEGMENT_DEF
) (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               time_load,
  input  logic [TIME_W-1:0]  time_load_value,
  input  logic               update_settings_in,
  input  logic [CYCLE_W-1:0] cycle    [NUM_SEGMENT],
  input  logic [DVS_W-1:0]   freq_div [NUM_SEGMENT],
  output logic [TIME_W-1:0]  sys_time,
  output logic [CYCLE_W-1:0] idx      [NUM_SEGMENT],
  output logic               update_settings_out
);

  logic [DVS_W-1:0] cycle_len_q [NUM_SEGMENT];
  logic [DVS_W-1:0] freq_div_q  [NUM_SEGMENT];

  ////////////////////////////////////////
  // Shared time and settings
  ////////////////////////////////////////
  sys_time_counter i_sys_time_counter (
    .CLK            (CLK),
    .rst_n          (rst_n),
    .time_load      (time_load),
    .time_load_value(time_load_value),
    .sys_time       (sys_time)
  );

  settings_buffer #(
    .NUM_SEGMENT(NUM_SEGMENT)
  ) i_settings_buffer (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .update_in  (update_settings_in),
    .cycle      (cycle),
    .freq_div_in(freq_div),
    .cycle_len  (cycle_len_q),
    .freq_div   (freq_div_q),
    .update_out (update_settings_out)
  );

  // One index unit per output segment
  for (genvar i = 0; i < NUM_SEGMENT; i++) begin : gen_idx
    modulation_index i_modulation_index (
      .CLK      (CLK),
      .rst_n    (rst_n),
      .sys_time (sys_time),
      .freq_div (freq_div_q[i]),
      .cycle_len(cycle_len_q[i]),
      .idx      (idx[i])
    );
  end

endmodule

`default_nettype wire

// ==== source/pipe_divider.sv ====
`default_nettype none

module pipe_divider #(
  parameter int DVD_W = 48,
  parameter int DVS_W = 16
) (
  input  logic             CLK,
  input  logic             rst_n,
  input  logic [DVD_W-1:0] dividend,
  input  logic [DVS_W-1:0] divisor,
  input  logic             in_valid,
  output logic [DVD_W-1:0] quotient,
  output logic [DVS_W-1:0] remainder,
  output logic             dout_valid
);

  // Stage 0 is the input register and stages 1..DVD_W each resolve one bit
  // dq_r shifts the dividend out at the top and the quotient in at the bottom
  logic [DVD_W-1:0] dq_r  [DVD_W+1];
  logic [DVS_W-1:0] rem_r [1:DVD_W];
  logic [DVS_W-1:0] dvs_r [DVD_W+1];
  logic [DVD_W:0]   vld_r;

  ////////////////////////////////////////
  // Input stage
  ////////////////////////////////////////
  always_ff @(posedge CLK) begin
    dq_r[0]  <= dividend;
    dvs_r[0] <= divisor;
  end

  // Valid bit rides along with the data
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      vld_r <= '0;
    end else begin
      vld_r <= {vld_r[DVD_W-1:0], in_valid};
    end
  end

  ////////////////////////////////////////
  // Restoring stages
  ////////////////////////////////////////
  for (genvar s = 1; s <= DVD_W; s++) begin : gen_stage
    logic [DVS_W:0]   shifted;
    logic [DVS_W+1:0] diff;

    // Bring down the next dividend bit
    if (s == 1) begin : gen_first
      assign shifted = {{DVS_W{1'b0}}, dq_r[0][DVD_W-1]}; // Empty partial remainder
    end else begin : gen_rest
      assign shifted = {rem_r[s-1], dq_r[s-1][DVD_W-1]};
    end
    assign diff = {1'b0, shifted} - {2'b00, dvs_r[s-1]};

    always_ff @(posedge CLK) begin
      dvs_r[s] <= dvs_r[s-1];
      if (diff[DVS_W+1]) begin // Borrow keeps the partial remainder
        rem_r[s] <= shifted[DVS_W-1:0];
        dq_r[s]  <= {dq_r[s-1][DVD_W-2:0], 1'b0};
      end else begin
        rem_r[s] <= diff[DVS_W-1:0];
        dq_r[s]  <= {dq_r[s-1][DVD_W-2:0], 1'b1};
      end
    end
  end

  // A zero divisor never borrows, so the quotient saturates to all ones
  // and the remainder collects the low dividend bits

  assign quotient   = dq_r[DVD_W];
  assign remainder  = rem_r[DVD_W];
  assign dout_valid = vld_r[DVD_W];

endmodule

`default_nettype wire

// ==== source/settings_buffer.sv ====
`default_nettype none

module settings_buffer
  import mod_timer_pkg::*;
#(
  parameter int NUM_SEGMENT = NUM_SEGMENT_DEF
) (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               update_in,
  input  logic [CYCLE_W-1:0] cycle       [NUM_SEGMENT],
  input  logic [DVS_W-1:0]   freq_div_in [NUM_SEGMENT],
  output logic [DVS_W-1:0]   cycle_len   [NUM_SEGMENT],
  output logic [DVS_W-1:0]   freq_div    [NUM_SEGMENT],
  output logic               update_out
);

  localparam int CNT_W = $clog2(SETTLE_LAT + 1);

  typedef enum logic {
    IDLE,
    SETTLE
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] cnt;
  logic             capture;

  assign capture = (state == IDLE) && update_in;

  ////////////////////////////////////////
  // Settle FSM
  ////////////////////////////////////////
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      cnt        <= '0;
      update_out <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          update_out <= 1'b0;
          cnt        <= '0;
          if (update_in) state <= SETTLE;
        end
        SETTLE: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(SETTLE_LAT)) begin // Pipeline has flushed
            update_out <= 1'b1;
            state      <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Per-segment settings, held between updates
  for (genvar i = 0; i < NUM_SEGMENT; i++) begin : gen_seg
    always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
        cycle_len[i] <= DVS_W'(1);
        freq_div[i]  <= DVS_W'(1);
      end else if (capture) begin
        cycle_len[i] <= {1'b0, cycle[i]} + 1'b1; // Modulus is cycle + 1
        freq_div[i]  <= freq_div_in[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/sys_time_counter.sv ====
`default_nettype none

module sys_time_counter
  import mod_timer_pkg::*;
(
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              time_load,
  input  logic [TIME_W-1:0] time_load_value,
  output logic [TIME_W-1:0] sys_time
);

  ////////////////////////////////////////
  // Free-running system time
  ////////////////////////////////////////

  // Wraps at 2**TIME_W

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      sys_time <= '0;
    end else if (time_load) begin
      sys_time <= time_load_value; // Load wins over count
    end else begin
      sys_time <= sys_time + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
source/mod_timer_pkg.sv
source/sys_time_counter.sv
source/pipe_divider.sv
source/settings_buffer.sv
source/modulation_index.sv
source/modulation_timer.sv
verif/tb_modulation_timer.sv

// ==== verif/tb_modulation_timer.sv ====
`default_nettype none

module tb_modulation_timer
  import mod_timer_pkg::*;
();

  localparam int NUM_SEG     = 2;
  localparam int SETTLE_CYC  = 100;
  localparam int IDX_LAT     = 99;  // Time sample to idx port
  localparam int HIST_AW     = 7;
  localparam int HIST_D      = 1 << HIST_AW;
  localparam int HOLD_CYC    = 260;
  localparam int RAND_ROUNDS = 6;
  localparam int NUM_ROUNDS  = RAND_ROUNDS + 3;
  localparam int TIMEOUT_CYC = NUM_ROUNDS * (SETTLE_CYC + 400) + 1500;
  localparam logic [31:0] RAND_SEED = 32'h4d4e_ee64;

  logic               CLK = 1'b0;
  logic               rst_n;
  logic               time_load;
  logic [TIME_W-1:0]  time_load_value;
  logic               update_settings_in;
  logic [CYCLE_W-1:0] cycle_in    [NUM_SEG];
  logic [DVS_W-1:0]   freq_div_in [NUM_SEG];
  logic [TIME_W-1:0]  sys_time;
  logic [CYCLE_W-1:0] idx         [NUM_SEG];
  logic               update_settings_out;

  // Settings for the next round
  logic [CYCLE_W-1:0] next_cycle [NUM_SEG];
  logic [DVS_W-1:0]   next_div   [NUM_SEG];

  ////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////
  logic [TIME_W-1:0]  hist [HIST_D];
  logic [TIME_W-1:0]  exp_time;
  logic [CYCLE_W-1:0] cur_cycle  [NUM_SEG];
  logic [DVS_W-1:0]   cur_div    [NUM_SEG];
  logic [CYCLE_W-1:0] pend_cycle [NUM_SEG];
  logic [DVS_W-1:0]   pend_div   [NUM_SEG];
  logic               busy;      // Buffer counting
  logic               check_en;  // Settings stable in the whole pipe
  int                 mon_cyc;
  int                 pulse_due;

  int err_cnt = 0;
  int to_cnt  = 0;
  int wd_cnt  = 0;

  modulation_timer #(
    .NUM_SEGMENT(NUM_SEG)
  ) i_modulation_timer (
    .CLK                (CLK),
    .rst_n              (rst_n),
    .time_load          (time_load),
    .time_load_value    (time_load_value),
    .update_settings_in (update_settings_in),
    .cycle              (cycle_in),
    .freq_div           (freq_div_in),
    .sys_time           (sys_time),
    .idx                (idx),
    .update_settings_out(update_settings_out)
  );

  always #20 CLK = ~CLK;

  // Index is floor((t >> 9) / freq_div) mod (cycle + 1)
  function automatic logic [CYCLE_W-1:0] expected_idx(input logic [TIME_W-1:0]  t,
                                                      input logic [DVS_W-1:0]   fd,
                                                      input logic [CYCLE_W-1:0] cyc);
    logic [TIME_W-1:0] shifted;
    logic [DVD_W-1:0]  cnt;
    logic [DVD_W-1:0]  len;
    logic [DVD_W-1:0]  rem;
    shifted = t >> TIME_SHIFT;
    cnt     = shifted[DVD_W-1:0];
    if (fd == '0) begin
      cnt = '1; // Zero divisor saturates
    end else begin
      cnt = cnt / DVD_W'(fd);
    end
    len = DVD_W'(cyc) + DVD_W'(1);
    rem = cnt % len;
    return rem[CYCLE_W-1:0];
  endfunction

  function automatic logic [TIME_W-1:0] random_time();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[TIME_W-1:0];
  endfunction

  // Close enough that the count wraps before the next load
  function automatic logic [TIME_W-1:0] near_wrap_time();
    return {TIME_W{1'b1}} - TIME_W'($urandom_range(0, 14));
  endfunction

  ////////////////////////////////////////
  // Monitor pass on each falling edge
  ////////////////////////////////////////
  task automatic check_and_advance();
    logic [HIST_AW-1:0] wr_ptr;
    logic [HIST_AW-1:0] rd_ptr;
    logic               exp_pulse;
    logic [CYCLE_W-1:0] exp_idx;
    wr_ptr = HIST_AW'(mon_cyc);
    rd_ptr = HIST_AW'(mon_cyc - IDX_LAT);
    hist[wr_ptr] = sys_time;

    assert (sys_time == exp_time) else begin
      err_cnt++;
      $display("ERROR: sys_time expected %h actual %h", exp_time, sys_time);
    end

    exp_pulse = busy && (mon_cyc == pulse_due);
    assert (update_settings_out == exp_pulse) else begin
      err_cnt++;
      $display("ERROR: update_settings_out expected %h actual %h",
               exp_pulse, update_settings_out);
    end

    if (check_en) begin
      for (int s = 0; s < NUM_SEG; s++) begin
        exp_idx = expected_idx(hist[rd_ptr], cur_div[s], cur_cycle[s]);
        assert (idx[s] == exp_idx) else begin
          err_cnt++;
          $display("ERROR: idx[%0d] expected %h actual %h", s, exp_idx, idx[s]);
        end
      end
    end

    if (exp_pulse) begin
      busy     = 1'b0;
      check_en = 1'b1;
      for (int s = 0; s < NUM_SEG; s++) begin
        cur_cycle[s] = pend_cycle[s];
        cur_div[s]   = pend_div[s];
      end
    end

    // Inputs seen now are sampled at the next rising edge
    if (update_settings_in && !busy) begin
      busy      = 1'b1;
      check_en  = 1'b0;
      pulse_due = (mon_cyc + 1) + SETTLE_CYC + 1;
      for (int s = 0; s < NUM_SEG; s++) begin
        pend_cycle[s] = cycle_in[s];
        pend_div[s]   = freq_div_in[s];
      end
    end

    exp_time = time_load ? time_load_value : exp_time + TIME_W'(1);
  endtask

  always @(negedge CLK) begin
    if (!rst_n) begin
      exp_time  = '0;
      busy      = 1'b0;
      check_en  = 1'b1;
      mon_cyc   = 0;
      pulse_due = 0;
      for (int i = 0; i < HIST_D; i++) begin
        hist[i] = '0;
      end
      for (int s = 0; s < NUM_SEG; s++) begin
        cur_cycle[s] = '0;         // cycle_len 1 after reset
        cur_div[s]   = DVS_W'(1);
      end
    end else begin
      check_and_advance();
      mon_cyc++;
    end
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////
  task automatic load_time(input logic [TIME_W-1:0] value);
    @(posedge CLK);
    time_load       <= 1'b1;
    time_load_value <= value;
    @(posedge CLK);
    time_load       <= 1'b0;
  endtask

  task automatic pulse_update();
    @(posedge CLK);
    update_settings_in <= 1'b1;
    @(posedge CLK);
    update_settings_in <= 1'b0;
  endtask

  task automatic send_settings();
    @(posedge CLK);
    update_settings_in <= 1'b1;
    for (int s = 0; s < NUM_SEG; s++) begin
      cycle_in[s]    <= next_cycle[s];
      freq_div_in[s] <= next_div[s];
    end
    @(posedge CLK);
    update_settings_in <= 1'b0;
    // Scramble after capture as the buffer keeps its copy
    for (int s = 0; s < NUM_SEG; s++) begin
      cycle_in[s]    <= CYCLE_W'($urandom);
      freq_div_in[s] <= DVS_W'($urandom);
    end
  endtask

  task automatic strobe_while_settling();
    repeat (3) begin
      repeat ($urandom_range(5, 20)) @(posedge CLK);
      pulse_update();
    end
  endtask

  task automatic wait_settled();
    @(negedge CLK);
    while (!update_settings_out) @(negedge CLK);
  endtask

  task automatic hold_window(input bit full_scale);
    int                left;
    int                gap;
    logic [TIME_W-1:0] t;
    left = HOLD_CYC;
    if (full_scale) begin
      // Count field all ones reaches the top index
      t = random_time();
      t[CYCLE_W+TIME_SHIFT-1:0] = {{CYCLE_W{1'b1}}, {TIME_SHIFT{1'b0}}};
      load_time(t);
      repeat (120) @(posedge CLK);
      left = left - 122;
    end
    while (left > 0) begin
      gap = $urandom_range(15, 40);
      repeat (gap) @(posedge CLK);
      if ($urandom_range(0, 3) == 0) begin
        load_time(near_wrap_time());
      end else begin
        load_time(random_time());
      end
      left = left - gap - 2;
    end
  endtask

  task automatic run_round(input bit full_scale);
    send_settings();
    strobe_while_settling();
    wait_settled();
    hold_window(full_scale);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin : stimulus
    void'($urandom(RAND_SEED));
    rst_n              = 1'b0;
    time_load          = 1'b0;
    time_load_value    = '0;
    update_settings_in = 1'b0;
    for (int s = 0; s < NUM_SEG; s++) begin
      cycle_in[s]    = '0;
      freq_div_in[s] = DVS_W'(1);
    end
    repeat (10) @(posedge CLK);
    rst_n <= 1'b1;

    repeat (150) @(posedge CLK); // Plain counting with idx held at 0

    for (int i = 0; i < 6; i++) begin
      if (i % 2 == 0) begin
        load_time(near_wrap_time());
      end else begin
        load_time(random_time());
      end
      repeat (20) @(posedge CLK);
    end

    for (int r = 0; r < RAND_ROUNDS; r++) begin
      for (int s = 0; s < NUM_SEG; s++) begin
        next_cycle[s] = CYCLE_W'($urandom_range(0, 32767));
        next_div[s]   = DVS_W'($urandom_range(1, 65535));
      end
      run_round(1'b0);
    end

    // Corner settings
    next_cycle[0] = '0;
    next_div[0]   = DVS_W'($urandom_range(1, 65535));
    next_cycle[1] = '1;
    next_div[1]   = DVS_W'(1);
    run_round(1'b1);

    next_cycle[0] = CYCLE_W'($urandom_range(0, 32767));
    next_div[0]   = DVS_W'(1);
    next_cycle[1] = '0;
    next_div[1]   = '0;
    run_round(1'b0);

    next_cycle[0] = '1;
    next_div[0]   = '0;
    next_cycle[1] = CYCLE_W'($urandom_range(1, 32766));
    next_div[1]   = '0;
    run_round(1'b0);

    $display("Checks done: %0d errors, %0d timeouts", err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    while (wd_cnt < TIMEOUT_CYC) begin
      @(posedge CLK);
      wd_cnt++;
    end
    to_cnt++;
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("Checks done: %0d errors, %0d timeouts", err_cnt, to_cnt);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire
